//--- filelist.f
logic/exec_pkg.sv
logic/pipe_register.sv
logic/mul_unit.sv
logic/exec_pipeline.sv
logic/exec_csr.sv
logic/exec_top.sv
testbench/exec_assertions.sv
testbench/exec_tb.sv

//--- logic/exec_csr.sv
// ----------------------------------------
// Execute lane control registers
// Run bit, completion and drop counters
// ----------------------------------------

`timescale 1ns/1ps

module exec_csr import exec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_wr,
    input  csr_addr_t   csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    input  exec_req_t   req,
    input  exec_rsp_t   rsp,
    output logic        run
);

    logic        run_q;
    logic [31:0] done_count;
    logic [31:0] drop_count;
    logic        drop_event;

    // Requests seen while frozen never enter the pipeline
    assign drop_event = req.valid & ~run_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b1;
        end else if (csr_wr && csr_addr == CSR_RUN) begin
            run_q <= csr_wdata[0];
        end
    end

    // A write clears the counter and wins over an event in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            done_count <= '0;
        end else if (csr_wr && csr_addr == CSR_DONE) begin
            done_count <= '0;
        end else if (rsp.valid) begin
            done_count <= done_count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (csr_wr && csr_addr == CSR_DROP) begin
            drop_count <= '0;
        end else if (drop_event) begin
            drop_count <= drop_count + 32'd1;
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_RUN:  csr_rdata = {31'd0, run_q};
            CSR_DONE: csr_rdata = done_count;
            CSR_DROP: csr_rdata = drop_count;
            default:  csr_rdata = '0;
        endcase
    end

    assign run = run_q;

endmodule

//--- logic/exec_pipeline.sv
// ----------------------------------------
// Integer execute pipeline
// Input stage, ALU and multiplier paths,
// result select and output retiming
// ----------------------------------------

`timescale 1ns/1ps

module exec_pipeline import exec_pkg::*; #(
    parameter int OUT_DEPTH = 1
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  exec_req_t req,
    output exec_rsp_t rsp
);

    // What travels beside the multiplier while it works
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        exec_op_t         op;
        logic [31:0]      result;
    } alu_stage_t;

    exec_req_t   req_q;
    alu_stage_t  alu_d;
    alu_stage_t  alu_q;
    logic [31:0] alu_result;
    logic [31:0] mul_product;
    exec_rsp_t   sel_rsp;
    exec_rsp_t   out_q;

    // Every stage is frozen by run, so a request that arrives while frozen
    // is never captured
    pipe_register #(
        .DATAW  ($bits(exec_req_t)),
        .RESETW (1),
        .DEPTH  (1)
    ) input_stage (
        .clk      (clk),
        .reset    (reset),
        .enable   (run),
        .data_in  (req),
        .data_out (req_q)
    );

    always_comb begin
        case (req_q.op)
            OP_ADD:  alu_result = req_q.a + req_q.b;
            OP_SUB:  alu_result = req_q.a - req_q.b;
            OP_AND:  alu_result = req_q.a & req_q.b;
            OP_OR:   alu_result = req_q.a | req_q.b;
            OP_XOR:  alu_result = req_q.a ^ req_q.b;
            OP_SLL:  alu_result = req_q.a << req_q.b[4:0];
            OP_SRL:  alu_result = req_q.a >> req_q.b[4:0];
            // Multiplies take their result from mul_unit at the end
            default: alu_result = '0;
        endcase
    end

    mul_unit mul (
        .clk     (clk),
        .reset   (reset),
        .enable  (run),
        .a       (req_q.a),
        .b       (req_q.b),
        .product (mul_product)
    );

    assign alu_d = '{valid: req_q.valid, tag: req_q.tag, op: req_q.op, result: alu_result};

    pipe_register #(
        .DATAW  ($bits(alu_stage_t)),
        .RESETW (1),
        .DEPTH  (MUL_STAGES)
    ) alu_delay (
        .clk      (clk),
        .reset    (reset),
        .enable   (run),
        .data_in  (alu_d),
        .data_out (alu_q)
    );

    assign sel_rsp.valid  = alu_q.valid;
    assign sel_rsp.tag    = alu_q.tag;
    assign sel_rsp.result = (alu_q.op == OP_MUL) ? mul_product : alu_q.result;

    pipe_register #(
        .DATAW  ($bits(exec_rsp_t)),
        .RESETW (1),
        .DEPTH  (OUT_DEPTH)
    ) output_stage (
        .clk      (clk),
        .reset    (reset),
        .enable   (run),
        .data_in  (sel_rsp),
        .data_out (out_q)
    );

    // A held output must not strobe again on every frozen cycle
    assign rsp.valid  = out_q.valid & run;
    assign rsp.tag    = out_q.tag;
    assign rsp.result = out_q.result;

endmodule

//--- logic/exec_pkg.sv
// ----------------------------------------
// Execute lane shared types
// Opcodes, request and response structs,
// CSR addresses and fixed stage counts
// ----------------------------------------

package exec_pkg;

    // Width of the request tag that returns with each result
    localparam int TAG_W = 4;

    // Fixed latency of the multiplier, matched on the ALU path
    localparam int MUL_STAGES = 2;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } exec_op_t;

    // Valid sits in the top bit so a stage can reset it alone
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        exec_op_t         op;
        logic [31:0]      a;
        logic [31:0]      b;
    } exec_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [31:0]      result;
    } exec_rsp_t;

    // Register map of the control block
    typedef enum logic [1:0] {
        CSR_RUN  = 2'd0,
        CSR_DONE = 2'd1,
        CSR_DROP = 2'd2
    } csr_addr_t;

endpackage

//--- logic/exec_top.sv
// ----------------------------------------
// Execute lane top level
// Control registers beside the pipeline
// ----------------------------------------

`timescale 1ns/1ps

module exec_top import exec_pkg::*; #(
    parameter int OUT_DEPTH = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  exec_req_t   req,
    output exec_rsp_t   rsp,
    input  logic        csr_wr,
    input  csr_addr_t   csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata
);

    logic run;

    // The control block watches both ends of the pipeline
    exec_csr csr (
        .clk       (clk),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .req       (req),
        .rsp       (rsp),
        .run       (run)
    );

    exec_pipeline #(
        .OUT_DEPTH (OUT_DEPTH)
    ) pipeline (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .req   (req),
        .rsp   (rsp)
    );

endmodule

//--- logic/mul_unit.sv
// ----------------------------------------
// Low-word multiplier
// Two stages over 16-bit partial products,
// yields the low 32 bits of a times b
// ----------------------------------------

`timescale 1ns/1ps

module mul_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] product
);

    logic [31:0] lo_lo_q;
    logic [15:0] hi_lo_q;
    logic [15:0] lo_hi_q;
    logic [31:0] product_q;
    logic [31:0] lo_lo_d;
    logic [31:0] hi_lo_d;
    logic [31:0] lo_hi_d;
    logic [15:0] cross_sum;

    assign lo_lo_d = a[15:0] * b[15:0];
    assign hi_lo_d = a[31:16] * b[15:0];
    assign lo_hi_d = a[15:0] * b[31:16];

    // Stage one keeps the full low product and only the low half of each
    // cross product, since their upper halves land beyond bit 31
    always_ff @(posedge clk) begin
        if (reset) begin
            lo_lo_q <= '0;
            hi_lo_q <= '0;
            lo_hi_q <= '0;
        end else if (enable) begin
            lo_lo_q <= lo_lo_d;
            hi_lo_q <= hi_lo_d[15:0];
            lo_hi_q <= lo_hi_d[15:0];
        end
    end

    assign cross_sum = hi_lo_q + lo_hi_q;

    // Stage two shifts the cross terms into the upper half and adds
    always_ff @(posedge clk) begin
        if (reset) begin
            product_q <= '0;
        end else if (enable) begin
            product_q <= lo_lo_q + {cross_sum, 16'h0000};
        end
    end

    assign product = product_q;

endmodule

//--- logic/pipe_register.sv
// ----------------------------------------
// Enable-gated pipe register
// Delays data by DEPTH enabled cycles and
// resets only the top RESETW bits
// ----------------------------------------

`timescale 1ns/1ps

module pipe_register #(
    parameter int DATAW  = 1,
    parameter int RESETW = 0,
    parameter int DEPTH  = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : gen_passthru
        // No storage at all, the stage collapses into a wire
        assign data_out = data_in;
    end else if (DEPTH == 1) begin : gen_single
        if (RESETW == 0) begin : gen_no_reset
            logic [DATAW-1:0] stage_q;

            always_ff @(posedge clk) begin
                if (enable) begin
                    stage_q <= data_in;
                end
            end
            assign data_out = stage_q;
        end else if (RESETW == DATAW) begin : gen_full_reset
            logic [DATAW-1:0] stage_q;

            always_ff @(posedge clk) begin
                if (reset) begin
                    stage_q <= '0;
                end else if (enable) begin
                    stage_q <= data_in;
                end
            end
            assign data_out = stage_q;
        end else begin : gen_part_reset
            // Control bits on top get a reset, the payload below does not
            logic [RESETW-1:0]       ctrl_q;
            logic [DATAW-RESETW-1:0] payload_q;

            always_ff @(posedge clk) begin
                if (reset) begin
                    ctrl_q <= '0;
                end else if (enable) begin
                    ctrl_q <= data_in[DATAW-1 -: RESETW];
                end
            end

            always_ff @(posedge clk) begin
                if (enable) begin
                    payload_q <= data_in[DATAW-RESETW-1:0];
                end
            end
            assign data_out = {ctrl_q, payload_q};
        end
    end else begin : gen_chain
        logic [DATAW-1:0] first_out;

        pipe_register #(
            .DATAW  (DATAW),
            .RESETW (RESETW),
            .DEPTH  (1)
        ) head (
            .clk      (clk),
            .reset    (reset),
            .enable   (enable),
            .data_in  (data_in),
            .data_out (first_out)
        );

        // The rest of the delay line is the same block one stage shorter
        pipe_register #(
            .DATAW  (DATAW),
            .RESETW (RESETW),
            .DEPTH  (DEPTH - 1)
        ) tail (
            .clk      (clk),
            .reset    (reset),
            .enable   (enable),
            .data_in  (first_out),
            .data_out (data_out)
        );
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute lane testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module exec_tb -f filelist.f -o exec_sim

status=0
./obj_dir/exec_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation did not complete cleanly"
    exit 1
fi
echo "Simulation passed"

//--- testbench/exec_assertions.sv
// ----------------------------------------
// Execute pipeline protocol assertions
// Bound into the pipeline from the testbench
// ----------------------------------------

`timescale 1ns/1ps

module exec_assertions import exec_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      run,
    input exec_rsp_t rsp,
    input exec_req_t req_q
);

    // No strobe may leave while reset is applied or in the cycle after it
    rsp_quiet_after_reset: assert property (
        @(posedge clk) (reset || $past(reset)) |-> !rsp.valid
    ) else $error("response strobe during or right after reset");

    rsp_quiet_when_frozen: assert property (
        @(posedge clk) !run |-> !rsp.valid
    ) else $error("response strobe while run is low");

    // A disabled input stage keeps its whole contents
    input_stage_holds: assert property (
        @(posedge clk) disable iff (reset) !run |=> $stable(req_q)
    ) else $error("input stage changed while run is low");

endmodule

//--- testbench/exec_tb.sv
// ----------------------------------------
// Execute lane testbench
// Table-driven requests, a reference model,
// freeze and counter checks
// ----------------------------------------

`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    typedef struct packed {
        exec_op_t         op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [TAG_W-1:0] tag;
        logic             run;
        logic             rnd;
    } step_t;

    typedef struct packed {
        logic [31:0]      step;
        logic [TAG_W-1:0] tag;
        logic [31:0]      result;
        logic [31:0]      stamp;
    } expect_t;

    localparam int NUM_STEPS = 17;

    logic        clk;
    logic        reset;
    exec_req_t   req;
    exec_rsp_t   rsp;
    logic        csr_wr;
    csr_addr_t   csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;

    step_t       steps [NUM_STEPS];
    expect_t     expect_q [$];
    logic [31:0] active_cycles;
    logic        run_model;
    int          seed;
    int          errors;
    int          resp_count;
    int          drops_sent;
    int          cur_step;

    exec_top #(.OUT_DEPTH(1)) dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .rsp       (rsp),
        .csr_wr    (csr_wr),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    bind exec_pipeline exec_assertions checks (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .rsp   (rsp),
        .req_q (req_q)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] expected_result(exec_op_t op, logic [31:0] a,
                                                    logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_MUL:  return a * b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Model of the run bit and of the active cycle count, updated at each edge
    // The stamp is the count as it stood when the request was driven
    always @(posedge clk) begin
        if (reset) begin
            run_model     <= 1'b1;
            active_cycles <= '0;
            drops_sent    <= 0;
        end else begin
            if (req.valid && run_model) begin
                expect_q.push_back('{cur_step, req.tag,
                                     expected_result(req.op, req.a, req.b),
                                     active_cycles});
            end
            if (req.valid && !run_model) drops_sent <= drops_sent + 1;
            if (run_model) active_cycles <= active_cycles + 32'd1;
            if (csr_wr && csr_addr == CSR_RUN) run_model <= csr_wdata[0];
        end
    end

    // Responses are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        expect_t exp_rsp;
        if (!reset && rsp.valid) begin
            resp_count++;
            if (!run_model) begin
                $display("Response strobe seen while the pipeline was frozen");
                errors++;
            end
            if (expect_q.size() == 0) begin
                $display("Response arrived with no request pending");
                errors++;
            end else begin
                exp_rsp = expect_q.pop_front();
                check_value($sformatf("step %0d tag", exp_rsp.step),
                            {28'd0, exp_rsp.tag}, {28'd0, rsp.tag});
                check_value($sformatf("step %0d result", exp_rsp.step),
                            exp_rsp.result, rsp.result);
                check_value($sformatf("step %0d latency", exp_rsp.step),
                            32'd4, active_cycles - exp_rsp.stamp);
            end
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_reg(input csr_addr_t addr, input logic [31:0] data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        idle_cycles(1);
        csr_wr    = 1'b0;
    endtask

    task automatic read_reg(input csr_addr_t addr, output logic [31:0] data);
        csr_addr = addr;
        #1;
        data = csr_rdata;
    endtask

    task automatic drive_request(input int idx);
        cur_step  = idx;
        req.valid = 1'b1;
        req.tag   = steps[idx].tag;
        req.op    = steps[idx].op;
        req.a     = steps[idx].rnd ? $random(seed) : steps[idx].a;
        req.b     = steps[idx].rnd ? $random(seed) : steps[idx].b;
        idle_cycles(1);
        req.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < 50) begin
            idle_cycles(1);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("Timed out with %0d responses still outstanding", expect_q.size());
            errors++;
        end
    endtask

    task automatic load_table();
        // op, a, b, tag, run, random operands
        steps[0]  = '{OP_ADD, 32'd5, 32'd7, 4'h1, 1'b1, 1'b0};
        steps[1]  = '{OP_SUB, 32'd3, 32'd10, 4'h2, 1'b1, 1'b0};
        steps[2]  = '{OP_AND, 32'hffff0000, 32'h12345678, 4'h3, 1'b1, 1'b0};
        steps[3]  = '{OP_OR, 32'h0f0f0f0f, 32'hf0f000ff, 4'h4, 1'b1, 1'b0};
        steps[4]  = '{OP_XOR, 32'haaaa5555, 32'hffff0000, 4'h5, 1'b1, 1'b0};
        steps[5]  = '{OP_SLL, 32'd1, 32'd35, 4'h6, 1'b1, 1'b0};
        steps[6]  = '{OP_SRL, 32'h80000000, 32'h3f, 4'h7, 1'b1, 1'b0};
        steps[7]  = '{OP_MUL, 32'hffffffff, 32'hffffffff, 4'h8, 1'b1, 1'b0};
        steps[8]  = '{OP_MUL, 32'h12345678, 32'h9abcdef0, 4'h9, 1'b1, 1'b0};
        steps[9]  = '{OP_MUL, 32'd0, 32'd0, 4'ha, 1'b1, 1'b1};
        steps[10] = '{OP_ADD, 32'd0, 32'd0, 4'hb, 1'b1, 1'b1};
        steps[11] = '{OP_SRL, 32'd0, 32'd0, 4'hc, 1'b1, 1'b1};
        // These two arrive while frozen and must be dropped
        steps[12] = '{OP_XOR, 32'd0, 32'd0, 4'hd, 1'b0, 1'b1};
        steps[13] = '{OP_ADD, 32'd1, 32'd2, 4'he, 1'b0, 1'b0};
        steps[14] = '{OP_SLL, 32'd0, 32'd0, 4'hf, 1'b1, 1'b1};
        steps[15] = '{OP_SUB, 32'd0, 32'd0, 4'h0, 1'b1, 1'b1};
        steps[16] = '{OP_MUL, 32'd0, 32'd0, 4'h1, 1'b1, 1'b1};
    endtask

    initial begin
        logic [31:0] rd;
        logic        cur_run;
        seed       = 32'h57cf9dd8;
        errors     = 0;
        resp_count = 0;
        cur_step   = 0;
        reset      = 1'b1;
        req        = '0;
        csr_wr     = 1'b0;
        csr_addr   = CSR_RUN;
        csr_wdata  = '0;
        load_table();
        idle_cycles(10);
        reset = 1'b0;
        idle_cycles(1);

        check_value("reset rsp valid", 32'd0, {31'd0, rsp.valid});
        read_reg(CSR_RUN, rd);
        check_value("reset run", 32'd1, rd);
        read_reg(CSR_DONE, rd);
        check_value("reset done count", 32'd0, rd);
        read_reg(CSR_DROP, rd);
        check_value("reset drop count", 32'd0, rd);

        idle_cycles(1);
        cur_run = 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].run != cur_run) begin
                cur_run = steps[i].run;
                write_reg(CSR_RUN, {31'd0, cur_run});
                // Give the frozen pipeline time to show that nothing leaks out
                if (!cur_run) idle_cycles(3);
            end
            drive_request(i);
        end
        if (!cur_run) write_reg(CSR_RUN, 32'd1);
        wait_drain();
        idle_cycles(2);

        read_reg(CSR_DONE, rd);
        check_value("done count", resp_count, rd);
        read_reg(CSR_DROP, rd);
        check_value("drop count", drops_sent, rd);
        idle_cycles(1);
        write_reg(CSR_DONE, 32'hdeadbeef);
        write_reg(CSR_DROP, 32'h1);
        read_reg(CSR_DONE, rd);
        check_value("done count clear", 32'd0, rd);
        read_reg(CSR_DROP, rd);
        check_value("drop count clear", 32'd0, rd);

        $display("Summary: %0d errors, %0d responses, %0d drops", errors, resp_count,
                 drops_sent);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
